/* sdram_ctrl.f */
rtl/sdram_pkg.sv
rtl/sdram_request_port.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_bank_tracker.sv
rtl/sdram_sequencer.sv
rtl/sdram_phy.sv
rtl/sdram_ctrl.sv
bench/sdram_model.sv
bench/sdram_ctrl_assert.sv
bench/tb_sdram_ctrl.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_sdram_ctrl \
        -f sdram_ctrl.f -o tb_sdram_ctrl \
    && ./obj_dir/tb_sdram_ctrl \
    || { echo "simulation failed"; exit 1; }

/* bench/tb_sdram_ctrl.sv */
`timescale 1ns/1ps

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int N_ENTRIES       = 21;
    localparam int CLK_HALF        = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int REFRESH_GAP_MAX = REFRESH_INTERVAL + 40;
    // 40 cycles per entry plus the three refresh intervals of the idle stretch
    localparam int CYCLE_LIMIT     = 40 * N_ENTRIES + 3 * REFRESH_INTERVAL;

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_IDLE = 2'd2;

    logic       clk;
    logic       rst;
    user_addr_t user_addr;
    logic       rw;
    word_t      data_in;
    logic       in_valid;
    logic       busy;
    word_t      data_out;
    logic       out_valid;
    logic       sdram_cke;
    logic       sdram_cs;
    logic       sdram_ras;
    logic       sdram_cas;
    logic       sdram_we;
    bank_t      sdram_ba;
    pin_addr_t  sdram_a;
    word_t      sdram_dqi;
    word_t      sdram_dqo;
    logic       sdram_dq_oe;

    // stimulus table
    logic [1:0] op_tab    [N_ENTRIES];
    user_addr_t addr_tab  [N_ENTRIES];
    word_t      wdata_tab [N_ENTRIES];
    word_t      exp_tab   [N_ENTRIES];
    logic       act_tab   [N_ENTRIES];
    logic       pre_tab   [N_ENTRIES];
    logic       junk_tab  [N_ENTRIES];
    int         n_tab = 0;
    logic [31:0] lcg_state = 32'h7da7ced4;

    // pin monitor state
    int         cycle_cnt = 0;
    int         cmd_cnt = 0;
    int         act_cnt = 0;
    int         pre_cnt = 0;
    int         wr_cnt = 0;
    int         rd_cnt = 0;
    int         ref_cnt = 0;
    int         act_cycle = 0;
    int         pre_cycle = 0;
    int         last_ref_cycle = 0;
    bank_t      last_act_bank = '0;
    pin_addr_t  last_act_row = '0;
    bank_t      last_pre_bank = '0;
    logic       prev_pre_all = 1'b0;
    cmd_t       pin_cmd;

    sdram_ctrl DUT (
        .clk         (clk),
        .rst         (rst),
        .user_addr   (user_addr),
        .rw          (rw),
        .data_in     (data_in),
        .in_valid    (in_valid),
        .busy        (busy),
        .data_out    (data_out),
        .out_valid   (out_valid),
        .sdram_cke   (sdram_cke),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqi   (sdram_dqi),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe)
    );

    sdram_model u_model (
        .clk   (clk),
        .cke   (sdram_cke),
        .cs    (sdram_cs),
        .ras   (sdram_ras),
        .cas   (sdram_cas),
        .we    (sdram_we),
        .ba    (sdram_ba),
        .a     (sdram_a),
        .dqo   (sdram_dqo),
        .dq_oe (sdram_dq_oe),
        .dqi   (sdram_dqi)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // hung run guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // command watch on the pins, incl. the refresh rules
    always @(posedge clk) begin
        pin_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
        if (rst) begin
            last_ref_cycle = cycle_cnt;
        end else if (pin_cmd != CMD_NOP) begin
            cmd_cnt++;
            case (pin_cmd)
                CMD_ACTIVE: begin
                    act_cnt++;
                    act_cycle     = cycle_cnt;
                    last_act_bank = sdram_ba;
                    last_act_row  = sdram_a;
                end
                CMD_PRECHARGE: begin
                    // all-bank precharge only counts toward refresh
                    if (!sdram_a[PRECHARGE_ALL_BIT]) begin
                        pre_cnt++;
                        pre_cycle     = cycle_cnt;
                        last_pre_bank = sdram_ba;
                    end
                end
                CMD_WRITE: wr_cnt++;
                CMD_READ: rd_cnt++;
                CMD_REFRESH: begin
                    check_value(32'(prev_pre_all), 32'd1, "refresh not after precharge all");
                    check_value(32'((cycle_cnt - last_ref_cycle) <= REFRESH_GAP_MAX), 32'd1,
                                "refresh interval too long");
                    ref_cnt++;
                    last_ref_cycle = cycle_cnt;
                end
                default: begin
                end
            endcase
            prev_pre_all = (pin_cmd == CMD_PRECHARGE) && sdram_a[PRECHARGE_ALL_BIT];
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_not_busy();
        while (busy) begin
            step_cycle();
        end
    endtask

    // expected read data is the last write to the same address above it
    task automatic add_entry(input logic [1:0] op, input row_t row, input bank_t bank,
                             input col_t col, input logic act, input logic pre,
                             input logic junk);
        int k;
        op_tab[n_tab]    = op;
        addr_tab[n_tab]  = {row, bank, col};
        act_tab[n_tab]   = act;
        pre_tab[n_tab]   = pre;
        junk_tab[n_tab]  = junk;
        wdata_tab[n_tab] = '0;
        exp_tab[n_tab]   = '0;
        if (op == OP_WR) begin
            lcg_state        = lcg_next(lcg_state);
            wdata_tab[n_tab] = lcg_state;
        end
        if (op == OP_RD) begin
            for (k = 0; k < n_tab; k++) begin
                if (op_tab[k] == OP_WR && addr_tab[k] == addr_tab[n_tab]) begin
                    exp_tab[n_tab] = wdata_tab[k];
                end
            end
        end
        n_tab++;
    endtask

    // op, row, bank, column, expect activate, expect precharge, junk pulse
    task automatic build_table();
        add_entry(OP_WR, 13'd5, 2'd0, 8'd3, 1'b1, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd5, 2'd0, 8'd3, 1'b0, 1'b0, 1'b0);
        add_entry(OP_WR, 13'd5, 2'd0, 8'd9, 1'b0, 1'b0, 1'b0);
        add_entry(OP_WR, 13'd7, 2'd1, 8'd4, 1'b1, 1'b0, 1'b0);
        add_entry(OP_WR, 13'd2, 2'd2, 8'd200, 1'b1, 1'b0, 1'b0);
        add_entry(OP_WR, 13'd8191, 2'd3, 8'd255, 1'b1, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd7, 2'd1, 8'd4, 1'b0, 1'b0, 1'b1);
        add_entry(OP_WR, 13'd9, 2'd0, 8'd3, 1'b1, 1'b1, 1'b0);
        add_entry(OP_RD, 13'd5, 2'd0, 8'd3, 1'b1, 1'b1, 1'b0);
        add_entry(OP_RD, 13'd9, 2'd0, 8'd3, 1'b1, 1'b1, 1'b0);
        add_entry(OP_RD, 13'd2, 2'd2, 8'd200, 1'b0, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd8191, 2'd3, 8'd255, 1'b0, 1'b0, 1'b0);
        add_entry(OP_WR, 13'd2, 2'd2, 8'd200, 1'b0, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd2, 2'd2, 8'd200, 1'b0, 1'b0, 1'b0);
        // refresh stretch closes every bank
        add_entry(OP_IDLE, 13'd0, 2'd0, 8'd0, 1'b0, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd5, 2'd0, 8'd9, 1'b1, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd7, 2'd1, 8'd4, 1'b1, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd8191, 2'd3, 8'd255, 1'b1, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd2, 2'd2, 8'd200, 1'b1, 1'b0, 1'b0);
        add_entry(OP_RD, 13'd9, 2'd0, 8'd3, 1'b1, 1'b1, 1'b0);
        add_entry(OP_RD, 13'd5, 2'd0, 8'd3, 1'b1, 1'b1, 1'b0);
    endtask

    // hold in_valid up to the accepting edge
    task automatic issue_request(input int i);
        wait_not_busy();
        user_addr = addr_tab[i];
        rw        = (op_tab[i] == OP_WR);
        data_in   = wdata_tab[i];
        in_valid  = 1'b1;
        step_cycle();
        if (junk_tab[i]) begin
            // second offer while busy, aimed at entry 0's word
            check_value(32'(busy), 32'd1, "busy after accepted request");
            user_addr = addr_tab[0];
            rw        = 1'b1;
            data_in   = ~data_in;
            step_cycle();
        end
        in_valid = 1'b0;
    endtask

    task automatic run_entry(input int i);
        int act0;
        int pre0;
        int wr0;
        int rd0;
        int ref0;
        if (op_tab[i] == OP_IDLE) begin
            ref0 = ref_cnt;
            while (ref_cnt < ref0 + 3) begin
                step_cycle();
            end
        end else begin
            act0 = act_cnt;
            pre0 = pre_cnt;
            wr0  = wr_cnt;
            rd0  = rd_cnt;
            issue_request(i);
            if (op_tab[i] == OP_RD) begin
                while (!out_valid) begin
                    step_cycle();
                end
                check_value(data_out, exp_tab[i], $sformatf("read data, entry %0d", i));
            end else begin
                // write done once its command left the pins
                while (wr_cnt == wr0) begin
                    step_cycle();
                end
            end
            check_value(32'(act_cnt - act0), 32'(act_tab[i]), "ACTIVE count");
            check_value(32'(pre_cnt - pre0), 32'(pre_tab[i]), "PRECHARGE count");
            check_value(32'(wr_cnt - wr0), 32'(op_tab[i] == OP_WR), "WRITE count");
            check_value(32'(rd_cnt - rd0), 32'(op_tab[i] == OP_RD), "READ count");
            if (act_tab[i]) begin
                check_value(32'(last_act_bank), 32'(addr_tab[i][9:8]), "ACTIVE bank");
                check_value(32'(last_act_row), 32'(addr_tab[i][22:10]), "ACTIVE row");
            end
            if (pre_tab[i]) begin
                check_value(32'(last_pre_bank), 32'(addr_tab[i][9:8]), "PRECHARGE bank");
                check_value(32'(pre_cycle < act_cycle), 32'd1, "PRECHARGE before ACTIVE");
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        user_addr = '0;
        rw        = 1'b0;
        data_in   = '0;
        in_valid  = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        wait_not_busy();
        repeat (4) step_cycle();
        check_value(32'(sdram_cke), 32'd1, "cke after reset");
        check_value(32'(cmd_cnt), 32'd0, "commands before first request");
        for (int i = 0; i < n_tab; i++) begin
            run_entry(i);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* bench/sdram_ctrl_assert.sv */
`timescale 1ns/1ps

module sdram_ctrl_assert (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic busy,
    input logic out_valid,
    input logic sdram_dq_oe,
    input logic sdram_cs,
    input logic sdram_ras,
    input logic sdram_cas,
    input logic sdram_we
);
    import sdram_pkg::*;

    cmd_t pin_cmd;

    assign pin_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    // read result is a single pulse
    out_valid_single : assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles in a row");

    // data bus driven only under a write command
    dq_oe_with_write : assert property (@(posedge clk) disable iff (rst)
        sdram_dq_oe |-> (pin_cmd == CMD_WRITE))
        else $error("dq_oe high without a write command on the pins");

    // accepted request blocks the port on the next cycle
    busy_after_accept : assert property (@(posedge clk) disable iff (rst)
        (in_valid && !busy) |=> busy)
        else $error("busy low in the cycle after an accepted request");

endmodule

bind sdram_ctrl sdram_ctrl_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .busy        (busy),
    .out_valid   (out_valid),
    .sdram_dq_oe (sdram_dq_oe),
    .sdram_cs    (sdram_cs),
    .sdram_ras   (sdram_ras),
    .sdram_cas   (sdram_cas),
    .sdram_we    (sdram_we)
);

/* bench/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model (
    input  logic                 clk,
    input  logic                 cke,
    input  logic                 cs,
    input  logic                 ras,
    input  logic                 cas,
    input  logic                 we,
    input  sdram_pkg::bank_t     ba,
    input  sdram_pkg::pin_addr_t a,
    input  sdram_pkg::word_t     dqo,
    input  logic                 dq_oe,
    output sdram_pkg::word_t     dqi
);
    import sdram_pkg::*;

    // open flag and open row per bank
    logic [NUM_BANKS-1:0] open_q = '0;
    row_t                 open_row [NUM_BANKS];
    // sparse storage, key is row, bank, word column
    word_t                mem [logic [22:0]];
    word_t                rd_q = '0;
    cmd_t                 cmd;
    logic [22:0]          key;

    assign cmd = {cs, ras, cas, we};
    assign key = {open_row[ba], ba, a[9:2]};
    assign dqi = rd_q;

    // never-written words, every address bit shows up in the value
    function automatic word_t fill_word(input logic [22:0] k);
        return {k[22:0], 9'h000} ^ {9'h000, k} ^ 32'h5a5a_0000;
    endfunction

    always @(posedge clk) begin
        if (cke) begin
            case (cmd)
                CMD_ACTIVE: begin
                    open_q[ba]   <= 1'b1;
                    open_row[ba] <= a;
                end
                CMD_PRECHARGE: begin
                    // a10 high closes every bank
                    if (a[PRECHARGE_ALL_BIT]) begin
                        open_q <= '0;
                    end else begin
                        open_q[ba] <= 1'b0;
                    end
                end
                CMD_WRITE: begin
                    // write into a closed bank is lost
                    if (dq_oe && open_q[ba]) begin
                        mem[key] = dqo;
                    end
                end
                CMD_READ: begin
                    // held until the next read
                    if (open_q[ba] && mem.exists(key)) begin
                        rd_q <= mem[key];
                    end else begin
                        rd_q <= fill_word(key);
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* rtl/sdram_ctrl.sv */
`timescale 1ns/1ps

module sdram_ctrl (
    input  logic                  clk,
    input  logic                  rst,

    // user side
    input  sdram_pkg::user_addr_t user_addr,
    input  logic                  rw,
    input  sdram_pkg::word_t      data_in,
    input  logic                  in_valid,
    output logic                  busy,
    output sdram_pkg::word_t      data_out,
    output logic                  out_valid,

    // sdram pins
    output logic                  sdram_cke,
    output logic                  sdram_cs,
    output logic                  sdram_ras,
    output logic                  sdram_cas,
    output logic                  sdram_we,
    output sdram_pkg::bank_t      sdram_ba,
    output sdram_pkg::pin_addr_t  sdram_a,
    input  sdram_pkg::word_t      sdram_dqi,
    output sdram_pkg::word_t      sdram_dqo,
    output logic                  sdram_dq_oe
);
    import sdram_pkg::*;

    // request fields seen by tracker and phy
    logic       pend;
    row_t       req_row;
    bank_t      req_bank;
    col_t       req_col;
    logic       req_rw;
    word_t      req_data;

    // sequencer handshakes
    logic       free_slot;
    logic       ref_due;
    logic       ref_start;
    logic       act_strobe;
    logic       pre_strobe;
    logic       idle;
    cmd_t       cmd;
    seq_state_t seq_state;

    // bank state
    logic       row_open;
    logic       row_hit;
    logic       pre_all;
    bank_t      pre_bank;

    sdram_request_port u_port (
        .clk       (clk),
        .rst       (rst),
        .user_addr (user_addr),
        .rw        (rw),
        .data_in   (data_in),
        .in_valid  (in_valid),
        .free_slot (free_slot),
        .busy      (busy),
        .pend      (pend),
        .req_row   (req_row),
        .req_bank  (req_bank),
        .req_col   (req_col),
        .req_rw    (req_rw),
        .req_data  (req_data)
    );

    sdram_refresh_timer u_refresh (
        .clk       (clk),
        .rst       (rst),
        .ref_start (ref_start),
        .ref_due   (ref_due)
    );

    sdram_bank_tracker u_banks (
        .clk        (clk),
        .rst        (rst),
        .req_row    (req_row),
        .req_bank   (req_bank),
        .act_strobe (act_strobe),
        .pre_strobe (pre_strobe),
        .ref_due    (ref_due),
        .idle       (idle),
        .row_open   (row_open),
        .row_hit    (row_hit),
        .pre_all    (pre_all),
        .pre_bank   (pre_bank)
    );

    sdram_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .pend       (pend),
        .req_rw     (req_rw),
        .ref_due    (ref_due),
        .row_open   (row_open),
        .row_hit    (row_hit),
        .cmd        (cmd),
        .seq_state  (seq_state),
        .free_slot  (free_slot),
        .ref_start  (ref_start),
        .act_strobe (act_strobe),
        .pre_strobe (pre_strobe),
        .idle       (idle)
    );

    sdram_phy u_phy (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .seq_state   (seq_state),
        .req_row     (req_row),
        .req_bank    (req_bank),
        .req_col     (req_col),
        .req_data    (req_data),
        .pre_all     (pre_all),
        .pre_bank    (pre_bank),
        .sdram_dqi   (sdram_dqi),
        .sdram_cke   (sdram_cke),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe),
        .data_out    (data_out),
        .out_valid   (out_valid)
    );

endmodule

/* rtl/sdram_phy.sv */
`timescale 1ns/1ps

module sdram_phy (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::cmd_t       cmd,
    input  sdram_pkg::seq_state_t seq_state,
    input  sdram_pkg::row_t       req_row,
    input  sdram_pkg::bank_t      req_bank,
    input  sdram_pkg::col_t       req_col,
    input  sdram_pkg::word_t      req_data,
    input  logic                  pre_all,
    input  sdram_pkg::bank_t      pre_bank,
    input  sdram_pkg::word_t      sdram_dqi,
    output logic                  sdram_cke,
    output logic                  sdram_cs,
    output logic                  sdram_ras,
    output logic                  sdram_cas,
    output logic                  sdram_we,
    output sdram_pkg::bank_t      sdram_ba,
    output sdram_pkg::pin_addr_t  sdram_a,
    output sdram_pkg::word_t      sdram_dqo,
    output logic                  sdram_dq_oe,
    output sdram_pkg::word_t      data_out,
    output logic                  out_valid
);
    import sdram_pkg::*;

    cmd_t      cmd_q;
    pin_addr_t pre_addr;
    word_t     dqi_q;

    // only a10 matters on precharge
    always_comb begin
        pre_addr = '0;
        pre_addr[PRECHARGE_ALL_BIT] = pre_all;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_cke <= 1'b0;
            cmd_q     <= CMD_NOP;
        end else begin
            // cke comes up during init and stays up
            if (seq_state == ST_INIT) begin
                sdram_cke <= 1'b1;
            end
            cmd_q <= cmd;
        end
    end

    // bank and address pins hold between commands
    always_ff @(posedge clk) begin
        case (seq_state)
            ST_INIT: begin
                sdram_a  <= MODE_REG_VALUE;
                sdram_ba <= '0;
            end
            ST_ACTIVATE: begin
                sdram_a  <= req_row;
                sdram_ba <= req_bank;
            end
            ST_READ, ST_WRITE: begin
                // word column, low two bits zero
                sdram_a  <= {3'b000, req_col, 2'b00};
                sdram_ba <= req_bank;
            end
            ST_PRECHARGE: begin
                sdram_a  <= pre_addr;
                sdram_ba <= pre_bank;
            end
            default: begin
                sdram_a  <= sdram_a;
                sdram_ba <= sdram_ba;
            end
        endcase
    end

    assign sdram_cs  = cmd_q[3];
    assign sdram_ras = cmd_q[2];
    assign sdram_cas = cmd_q[1];
    assign sdram_we  = cmd_q[0];

    // write word lines up with the write command on the pins
    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_dq_oe <= 1'b0;
        end else begin
            sdram_dq_oe <= seq_state == ST_WRITE;
        end
    end

    always_ff @(posedge clk) begin
        if (seq_state == ST_WRITE) begin
            sdram_dqo <= req_data;
        end
    end

    // read path, pin sample then result register
    always_ff @(posedge clk) begin
        dqi_q <= sdram_dqi;
        if (seq_state == ST_READ_RES) begin
            data_out <= dqi_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= seq_state == ST_READ_RES;
        end
    end

endmodule

/* rtl/sdram_sequencer.sv */
`timescale 1ns/1ps

module sdram_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pend,
    input  logic                  req_rw,
    input  logic                  ref_due,
    input  logic                  row_open,
    input  logic                  row_hit,
    output sdram_pkg::cmd_t       cmd,
    output sdram_pkg::seq_state_t seq_state,
    output logic                  free_slot,
    output logic                  ref_start,
    output logic                  act_strobe,
    output logic                  pre_strobe,
    output logic                  idle
);
    import sdram_pkg::*;

    seq_state_t         state;
    seq_state_t         state_nxt;
    // where the wait state goes when the counter runs out
    seq_state_t         ret_state;
    seq_state_t         ret_nxt;
    logic [DELAY_W-1:0] delay;
    logic [DELAY_W-1:0] delay_nxt;

    always_comb begin
        state_nxt = state;
        ret_nxt   = ret_state;
        delay_nxt = delay;
        case (state)
            ST_INIT: begin
                state_nxt = ST_WAIT;
                ret_nxt   = ST_IDLE;
                delay_nxt = '0;
            end
            ST_WAIT: begin
                if (delay == '0) begin
                    state_nxt = ret_state;
                end else begin
                    delay_nxt = delay - 1'b1;
                end
            end
            ST_IDLE: begin
                if (ref_due) begin
                    // close every bank before refresh
                    state_nxt = ST_PRECHARGE;
                    ret_nxt   = ST_REFRESH;
                end else if (pend) begin
                    if (row_hit) begin
                        state_nxt = req_rw ? ST_WRITE : ST_READ;
                    end else if (row_open) begin
                        // wrong row open in this bank
                        state_nxt = ST_PRECHARGE;
                        ret_nxt   = ST_ACTIVATE;
                    end else begin
                        state_nxt = ST_ACTIVATE;
                    end
                end
            end
            ST_REFRESH: begin
                state_nxt = ST_WAIT;
                ret_nxt   = ST_IDLE;
                delay_nxt = T_REF_WAIT;
            end
            ST_ACTIVATE: begin
                state_nxt = ST_WAIT;
                ret_nxt   = req_rw ? ST_WRITE : ST_READ;
                delay_nxt = T_ACT_WAIT;
            end
            ST_READ: begin
                state_nxt = ST_WAIT;
                ret_nxt   = ST_READ_RES;
                delay_nxt = T_CAS_WAIT;
            end
            ST_PRECHARGE: begin
                // return state was set in idle
                state_nxt = ST_WAIT;
                delay_nxt = T_PRE_WAIT;
            end
            ST_READ_RES, ST_WRITE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_INIT;
            ret_state <= ST_IDLE;
            delay     <= '0;
        end else begin
            state     <= state_nxt;
            ret_state <= ret_nxt;
            delay     <= delay_nxt;
        end
    end

    // command for the current state, registered in the phy
    always_comb begin
        case (state)
            ST_REFRESH:   cmd = CMD_REFRESH;
            ST_ACTIVATE:  cmd = CMD_ACTIVE;
            ST_READ:      cmd = CMD_READ;
            ST_WRITE:     cmd = CMD_WRITE;
            ST_PRECHARGE: cmd = CMD_PRECHARGE;
            default:      cmd = CMD_NOP;
        endcase
    end

    assign seq_state  = state;
    assign idle       = state == ST_IDLE;
    // init also frees the port so busy drops right after reset
    assign free_slot  = (state == ST_INIT) || (idle && !ref_due);
    assign ref_start  = idle && ref_due;
    assign act_strobe = state == ST_ACTIVATE;
    assign pre_strobe = state == ST_PRECHARGE;

endmodule

/* rtl/sdram_bank_tracker.sv */
`timescale 1ns/1ps

module sdram_bank_tracker (
    input  logic             clk,
    input  logic             rst,
    input  sdram_pkg::row_t  req_row,
    input  sdram_pkg::bank_t req_bank,
    input  logic             act_strobe,
    input  logic             pre_strobe,
    input  logic             ref_due,
    input  logic             idle,
    output logic             row_open,
    output logic             row_hit,
    output logic             pre_all,
    output sdram_pkg::bank_t pre_bank
);
    import sdram_pkg::*;

    // one open flag and one open row per bank
    logic [NUM_BANKS-1:0] open_q;
    row_t                 row_tab [NUM_BANKS];

    assign row_open = open_q[req_bank];
    // hit only counts on an open bank
    assign row_hit  = row_open && (row_tab[req_bank] == req_row);

    // precharge target, refresh wins over a row miss
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_all  <= 1'b0;
            pre_bank <= '0;
        end else if (idle && ref_due) begin
            pre_all  <= 1'b1;
            pre_bank <= '0;
        end else if (row_open && !row_hit) begin
            pre_all  <= 1'b0;
            pre_bank <= req_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (act_strobe) begin
            open_q[req_bank] <= 1'b1;
        end else if (pre_strobe) begin
            if (pre_all) begin
                open_q <= '0;
            end else begin
                open_q[pre_bank] <= 1'b0;
            end
        end
    end

    // row table only means something where open_q is set
    always_ff @(posedge clk) begin
        if (act_strobe) begin
            row_tab[req_bank] <= req_row;
        end
    end

endmodule

/* rtl/sdram_refresh_timer.sv */
`timescale 1ns/1ps

module sdram_refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic ref_start,
    output logic ref_due
);
    import sdram_pkg::*;

    logic [REF_CNT_W-1:0] ref_cnt;
    logic                 wrap;

    // interval elapsed
    assign wrap = ref_cnt > REFRESH_INTERVAL;

    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt <= '0;
        end else if (wrap) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // held until the sequencer takes the refresh
    always_ff @(posedge clk) begin
        if (rst) begin
            ref_due <= 1'b0;
        end else if (ref_start) begin
            ref_due <= 1'b0;
        end else if (wrap) begin
            ref_due <= 1'b1;
        end
    end

endmodule

/* rtl/sdram_request_port.sv */
`timescale 1ns/1ps

module sdram_request_port (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::user_addr_t user_addr,
    input  logic                  rw,
    input  sdram_pkg::word_t      data_in,
    input  logic                  in_valid,
    input  logic                  free_slot,
    output logic                  busy,
    output logic                  pend,
    output sdram_pkg::row_t       req_row,
    output sdram_pkg::bank_t      req_bank,
    output sdram_pkg::col_t       req_col,
    output logic                  req_rw,
    output sdram_pkg::word_t      req_data
);
    import sdram_pkg::*;

    logic  ready;
    logic  accept;
    logic  start;

    // request waiting for the sequencer
    row_t  hold_row;
    bank_t hold_bank;
    col_t  hold_col;
    logic  hold_rw;
    word_t hold_data;

    // request the sequencer is working on
    row_t  act_row;
    bank_t act_bank;
    col_t  act_col;
    logic  act_rw;
    word_t act_data;

    assign accept = ready && in_valid;
    // sequencer free and a request waiting, so it starts now
    assign start  = free_slot && !ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b0;
        end else if (start) begin
            ready <= 1'b1;
        end else if (accept) begin
            ready <= 1'b0;
        end
    end

    // split the user address straight into row, bank, column
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_row  <= user_addr[22:10];
            hold_bank <= user_addr[9:8];
            hold_col  <= user_addr[7:0];
            hold_rw   <= rw;
            hold_data <= data_in;
        end
    end

    // copy on start so a new request can wait behind it
    always_ff @(posedge clk) begin
        if (start) begin
            act_row  <= hold_row;
            act_bank <= hold_bank;
            act_col  <= hold_col;
            act_rw   <= hold_rw;
            act_data <= hold_data;
        end
    end

    // idle decision looks at the waiting one, commands use the started one
    assign req_row  = free_slot ? hold_row  : act_row;
    assign req_bank = free_slot ? hold_bank : act_bank;
    assign req_col  = free_slot ? hold_col  : act_col;
    assign req_rw   = free_slot ? hold_rw   : act_rw;
    assign req_data = free_slot ? hold_data : act_data;

    assign busy = !ready;
    assign pend = !ready;

endmodule

/* rtl/sdram_pkg.sv */
package sdram_pkg;

    // data and address widths
    typedef logic [31:0] word_t;
    // user address layout is row 22..10, bank 9..8, column 7..0
    typedef logic [22:0] user_addr_t;
    typedef logic [12:0] row_t;
    typedef logic [1:0]  bank_t;
    typedef logic [7:0]  col_t;
    typedef logic [12:0] pin_addr_t;
    // cs, ras, cas, we
    typedef logic [3:0]  cmd_t;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_WAIT,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_READ,
        ST_READ_RES,
        ST_WRITE,
        ST_PRECHARGE
    } seq_state_t;

    localparam int NUM_BANKS = 4;

    // command encodings, cs ras cas we
    localparam cmd_t CMD_NOP       = 4'b0111;
    localparam cmd_t CMD_ACTIVE    = 4'b0011;
    localparam cmd_t CMD_READ      = 4'b0101;
    localparam cmd_t CMD_WRITE     = 4'b0100;
    localparam cmd_t CMD_PRECHARGE = 4'b0010;
    localparam cmd_t CMD_REFRESH   = 4'b0001;

    // wait counts load n and run down to zero, so n+1 clocks
    localparam int DELAY_W = 3;
    localparam logic [DELAY_W-1:0] T_ACT_WAIT = 3'd2;
    localparam logic [DELAY_W-1:0] T_CAS_WAIT = 3'd2;
    localparam logic [DELAY_W-1:0] T_PRE_WAIT = 3'd2;
    localparam logic [DELAY_W-1:0] T_REF_WAIT = 3'd6;

    // clocks between refresh requests
    localparam int REF_CNT_W = 10;
    localparam logic [REF_CNT_W-1:0] REFRESH_INTERVAL = 10'd750;

    // mode register: burst length 4, sequential, cas latency 2
    localparam pin_addr_t MODE_REG_VALUE = 13'b000_0_00_010_0_010;

    // a10 selects all banks on precharge
    localparam int PRECHARGE_ALL_BIT = 10;

endpackage
